//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_compute_cluster
FILELIST  ?= all.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

//--- all.f
hdl/cc_pkg.sv
hdl/warp_table.sv
hdl/cluster_ctrl.sv
hdl/done_fifo.sv
hdl/compute_cluster.sv
hdl/compute_cluster_synth_wrapper.sv
dv/tb_clock_gen.sv
dv/tb_compute_cluster.sv

//--- dv/tb_clock_gen.sv
/*
 * Testbench clock and reset
 * 100 ns clock, reset held low for the first 3 cycles
 */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HalfPeriod = 50
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #HalfPeriod clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the DUT clock edge
    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule : tb_clock_gen

//--- dv/tb_compute_cluster.sv
/*
 * Compute cluster testbench
 * Instruction-memory model, fetch and completion logs, directed tests
 */
`timescale 1ns/1ps

module tb_compute_cluster;

    localparam int NumWarps  = 8;
    localparam int DoneDepth = 4;
    localparam int LogSize   = 256;
    localparam int Timeout   = 2000;

    logic clk;
    logic rst_n;

    logic               allocate_warp = 1'b0;
    cc_pkg::pc_t        alloc_pc      = '0;
    cc_pkg::addr_t      alloc_dp_addr = '0;
    cc_pkg::tblock_idx_t alloc_tblock = '0;
    cc_pkg::tgroup_id_t alloc_tgroup  = '0;
    logic               done_ready    = 1'b1;
    logic               ar_ready      = 1'b0;
    logic               r_valid       = 1'b0;
    cc_pkg::warp_idx_t  r_id          = '0;
    cc_pkg::inst_t      r_data        = '0;

    logic               warp_free;
    logic               done_valid;
    cc_pkg::tgroup_id_t done_id;
    logic               ar_valid;
    cc_pkg::warp_idx_t  ar_id;
    cc_pkg::imem_addr_t ar_addr;
    logic               r_ready;

    cc_pkg::inst_t      imem [256];
    cc_pkg::warp_idx_t  fetch_id   [LogSize];
    cc_pkg::imem_addr_t fetch_addr [LogSize];
    cc_pkg::tgroup_id_t done_log   [LogSize];
    cc_pkg::imem_addr_t exp_addr   [64];
    int                 fetch_cnt   = 0;
    int                 done_cnt    = 0;
    int                 exp_cnt     = 0;
    int                 seed        = 50;
    int                 mem_phase   = 0;
    int                 mem_wait    = 0;
    cc_pkg::warp_idx_t  req_id;
    cc_pkg::imem_addr_t req_addr;

    tb_clock_gen i_clk_gen (
        .clk_o  ( clk   ),
        .rst_n_o( rst_n )
    );

    compute_cluster_synth_wrapper #(
        .NumWarps ( NumWarps  ),
        .DoneDepth( DoneDepth )
    ) uut (
        .clk_i                ( clk           ),
        .rst_n_i              ( rst_n         ),
        .warp_free_o          ( warp_free     ),
        .allocate_warp_i      ( allocate_warp ),
        .allocate_pc_i        ( alloc_pc      ),
        .allocate_dp_addr_i   ( alloc_dp_addr ),
        .allocate_tblock_idx_i( alloc_tblock  ),
        .allocate_tgroup_id_i ( alloc_tgroup  ),
        .tblock_done_ready_i  ( done_ready    ),
        .tblock_done_o        ( done_valid    ),
        .tblock_done_id_o     ( done_id       ),
        .imem_ar_valid_o      ( ar_valid      ),
        .imem_ar_id_o         ( ar_id         ),
        .imem_ar_addr_o       ( ar_addr       ),
        .imem_ar_ready_i      ( ar_ready      ),
        .imem_r_valid_i       ( r_valid       ),
        .imem_r_id_i          ( r_id          ),
        .imem_r_data_i        ( r_data        ),
        .imem_r_ready_o       ( r_ready       )
    );

    // Memory model with random accept and response delays of 0 to 3 cycles
    always @(negedge clk) begin
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        if (!rst_n) begin
            mem_phase = 0;
        end else if (mem_phase == 0) begin
            if (ar_valid && mem_wait == 0) begin
                ar_ready  = 1'b1;
                req_id    = ar_id;
                req_addr  = ar_addr;
                mem_wait  = $unsigned($random(seed)) % 4;
                mem_phase = 1;
                if (fetch_cnt < LogSize) begin
                    fetch_id[fetch_cnt]   = ar_id;
                    fetch_addr[fetch_cnt] = ar_addr;
                    fetch_cnt++;
                end
            end else if (ar_valid) begin
                mem_wait--;
            end
        end else if (mem_wait == 0) begin
            // The fetch is in flight, so the read data channel must be open
            check_value("imem_r_ready_o", 32'(r_ready), 1);
            r_valid   = 1'b1;
            r_id      = req_id;
            r_data    = imem[req_addr[9:2]];
            mem_wait  = $unsigned($random(seed)) % 4;
            mem_phase = 0;
        end else begin
            mem_wait--;
        end
    end

    // An entry leaves the queue on a clock edge with valid and ready high
    always @(posedge clk) begin
        if (rst_n && done_valid && done_ready && done_cnt < LogSize) begin
            done_log[done_cnt] = done_id;
            done_cnt++;
        end
    end

    task automatic stop_failed();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
            stop_failed();
        end
    endtask

    function automatic cc_pkg::inst_t make_inst(input cc_pkg::opcode_e op,
                                                input cc_pkg::pc_t tgt);
        return {op, 14'h0, tgt};
    endfunction

    function automatic int count_fetches(input cc_pkg::imem_addr_t addr);
        int hits;
        hits = 0;
        for (int i = 0; i < fetch_cnt; i++) begin
            if (fetch_addr[i] == addr) begin
                hits++;
            end
        end
        return hits;
    endfunction

    // Walk the program by the ISA rules to get the expected fetch addresses
    task automatic build_expected(input cc_pkg::pc_t start_pc);
        cc_pkg::pc_t   pc;
        cc_pkg::inst_t inst;
        logic          ended;
        pc      = start_pc;
        ended   = 1'b0;
        exp_cnt = 0;
        while (!ended && exp_cnt < 64) begin
            exp_addr[exp_cnt] = {pc, 2'b00};
            exp_cnt++;
            inst = imem[pc[7:0]];
            case (inst[31:30])
                2'd1:    pc = inst[15:0];
                2'd2:    ended = 1'b1;
                default: pc = pc + 16'd1;
            endcase
        end
    endtask

    task automatic check_stream(input cc_pkg::warp_idx_t id, input cc_pkg::pc_t start_pc);
        int n;
        n = 0;
        build_expected(start_pc);
        for (int i = 0; i < fetch_cnt; i++) begin
            if (fetch_id[i] == id) begin
                if (n >= exp_cnt) begin
                    $display("Warp %0d fetched past the end of its program", id);
                    stop_failed();
                end
                check_value("imem_ar_addr_o", 32'(fetch_addr[i]), 32'(exp_addr[n]));
                n++;
            end
        end
        check_value("fetch count", n, exp_cnt);
    endtask

    task automatic check_once(input cc_pkg::tgroup_id_t gid);
        int hits;
        hits = 0;
        for (int i = 0; i < done_cnt; i++) begin
            if (done_log[i] == gid) begin
                hits++;
            end
        end
        check_value("tblock_done_id_o hits", hits, 1);
    endtask

    task automatic clear_logs();
        fetch_cnt = 0;
        done_cnt  = 0;
    endtask

    task automatic wait_free();
        int t;
        t = 0;
        while (!warp_free && t < Timeout) begin
            @(negedge clk);
            t++;
        end
        if (!warp_free) begin
            $display("Timeout while waiting for a free warp slot");
            stop_failed();
        end
    endtask

    task automatic wait_done(input int n);
        int t;
        t = 0;
        while (done_cnt < n && t < Timeout) begin
            @(negedge clk);
            t++;
        end
        if (done_cnt < n) begin
            $display("Timeout with %0d of %0d block completions seen", done_cnt, n);
            stop_failed();
        end
    endtask

    task automatic start_block(input cc_pkg::pc_t pc, input cc_pkg::tgroup_id_t gid);
        wait_free();
        allocate_warp = 1'b1;
        alloc_pc      = pc;
        alloc_dp_addr = 32'h8000_0000 | 32'(gid);
        alloc_tblock  = gid ^ 8'hff;
        alloc_tgroup  = gid;
        @(negedge clk);
        allocate_warp = 1'b0;
    endtask

    task automatic test_reset_and_fill();
        check_value("warp_free_o", 32'(warp_free), 1);
        check_value("tblock_done_o", 32'(done_valid), 0);
        check_value("imem_ar_valid_o", 32'(ar_valid), 0);
        check_value("imem_r_ready_o", 32'(r_ready), 0);
        clear_logs();
        imem['h08] = make_inst(cc_pkg::OP_JUMP, 16'h0008);
        for (int i = 0; i < NumWarps; i++) begin
            start_block(16'h0008, 8'(i + 1));
        end
        check_value("warp_free_o", 32'(warp_free), 0);
        // Turn the spin loop into an exit so the table drains
        imem['h08] = make_inst(cc_pkg::OP_EXIT, 16'h0000);
        wait_done(NumWarps);
        for (int i = 0; i < NumWarps; i++) begin
            check_once(8'(i + 1));
        end
        for (int i = 0; i < fetch_cnt; i++) begin
            check_value("imem_ar_addr_o", 32'(fetch_addr[i]), 32'h20);
        end
        check_value("warp_free_o", 32'(warp_free), 1);
    endtask

    task automatic test_straight_line();
        clear_logs();
        imem['h10] = make_inst(cc_pkg::OP_NOP, 16'h0000);
        imem['h11] = make_inst(cc_pkg::OP_NOP, 16'h0000);
        imem['h12] = make_inst(cc_pkg::OP_EXIT, 16'h0000);
        start_block(16'h0010, 8'h21);
        wait_done(1);
        repeat (20) @(negedge clk);
        check_value("completion count", done_cnt, 1);
        check_value("tblock_done_id_o", 32'(done_log[0]), 32'h21);
        check_stream(3'd0, 16'h0010);
    endtask

    task automatic test_jump();
        clear_logs();
        imem['h20] = make_inst(cc_pkg::OP_JUMP, 16'h0030);
        imem['h21] = make_inst(cc_pkg::OP_NOP, 16'h0000);
        imem['h30] = make_inst(cc_pkg::OP_EXIT, 16'h0000);
        start_block(16'h0020, 8'h31);
        wait_done(1);
        repeat (20) @(negedge clk);
        check_value("completion count", done_cnt, 1);
        check_once(8'h31);
        check_stream(3'd0, 16'h0020);
    endtask

    task automatic test_interleaved();
        clear_logs();
        imem['h40] = make_inst(cc_pkg::OP_NOP, 16'h0000);
        imem['h41] = make_inst(cc_pkg::OP_NOP, 16'h0000);
        imem['h42] = make_inst(cc_pkg::OP_NOP, 16'h0000);
        imem['h43] = make_inst(cc_pkg::OP_EXIT, 16'h0000);
        imem['h50] = make_inst(cc_pkg::OP_JUMP, 16'h0058);
        imem['h58] = make_inst(cc_pkg::OP_NOP, 16'h0000);
        imem['h59] = make_inst(cc_pkg::OP_EXIT, 16'h0000);
        imem['h60] = make_inst(cc_pkg::OP_JUMP, 16'h0064);
        imem['h64] = make_inst(cc_pkg::OP_EXIT, 16'h0000);
        start_block(16'h0040, 8'h41);
        start_block(16'h0050, 8'h42);
        start_block(16'h0060, 8'h43);
        wait_done(3);
        repeat (20) @(negedge clk);
        check_value("completion count", done_cnt, 3);
        for (int i = 0; i < 3; i++) begin
            check_once(8'h41 + 8'(i));
        end
        check_stream(3'd0, 16'h0040);
        check_stream(3'd1, 16'h0050);
        check_stream(3'd2, 16'h0060);
    endtask

    task automatic test_backpressure();
        int t;
        int held_fetches;
        clear_logs();
        done_ready = 1'b0;
        imem['h70] = make_inst(cc_pkg::OP_NOP, 16'h0000);
        imem['h71] = make_inst(cc_pkg::OP_EXIT, 16'h0000);
        imem['h78] = make_inst(cc_pkg::OP_JUMP, 16'h0078);
        // Two spinning warps keep the table full until the exits drain
        start_block(16'h0078, 8'h51);
        start_block(16'h0078, 8'h52);
        for (int i = 0; i < 6; i++) begin
            start_block(16'h0070, 8'h60 + 8'(i));
        end
        check_value("warp_free_o", 32'(warp_free), 0);
        // Four exits fill the queue, the fifth stalls in execute
        t = 0;
        while (count_fetches(18'h001c4) < 5 && t < Timeout) begin
            @(negedge clk);
            t++;
        end
        if (count_fetches(18'h001c4) < 5) begin
            $display("Timeout while waiting for the fifth EXIT fetch");
            stop_failed();
        end
        held_fetches = fetch_cnt;
        repeat (40) @(negedge clk);
        check_value("completion count", done_cnt, 0);
        check_value("tblock_done_o", 32'(done_valid), 1);
        check_value("fetch count while stalled", fetch_cnt, held_fetches);
        check_value("warp_free_o", 32'(warp_free), 1);
        done_ready = 1'b1;
        wait_done(6);
        for (int i = 0; i < 6; i++) begin
            check_once(8'h60 + 8'(i));
        end
        imem['h78] = make_inst(cc_pkg::OP_EXIT, 16'h0000);
        wait_done(8);
        check_once(8'h51);
        check_once(8'h52);
        check_value("warp_free_o", 32'(warp_free), 1);
    endtask

    task automatic test_reserved_opcode();
        clear_logs();
        imem['h90] = make_inst(cc_pkg::OP_RSVD, 16'h1234);
        imem['h91] = make_inst(cc_pkg::OP_EXIT, 16'h0000);
        start_block(16'h0090, 8'h66);
        wait_done(1);
        repeat (20) @(negedge clk);
        check_value("completion count", done_cnt, 1);
        check_once(8'h66);
        check_stream(3'd0, 16'h0090);
    endtask

    initial begin
        int t;
        // Unused words retire the warp, low bits carry the word address
        for (int i = 0; i < 256; i++) begin
            imem[i] = {2'b10, 30'(i)};
        end
        t = 0;
        while (!rst_n && t < 20) begin
            @(posedge clk);
            t++;
        end
        if (!rst_n) begin
            $display("Reset was never released");
            stop_failed();
        end
        @(negedge clk);
        test_reset_and_fill();
        test_straight_line();
        test_jump();
        test_interleaved();
        test_backpressure();
        test_reserved_opcode();
        $display("NO ERRORS");
        $finish;
    end

endmodule : tb_compute_cluster

//--- hdl/cc_pkg.sv
/*
 * Compute cluster package
 * Shared widths, instruction encoding, FSM states and port structs
 */
package cc_pkg;

    // PC counts instructions, not bytes
    localparam int unsigned PcWidth = 16;

    typedef logic [PcWidth-1:0]   pc_t;
    typedef logic [PcWidth+1:0]   imem_addr_t;
    typedef logic [31:0]          addr_t;
    typedef logic [7:0]           tblock_idx_t;
    typedef logic [7:0]           tgroup_id_t;
    typedef logic [31:0]          inst_t;
    typedef logic [2:0]           warp_idx_t;

    // Opcode sits in bits 31..30, jump target in bits 15..0
    typedef enum logic [1:0] {
        OP_NOP  = 2'd0,
        OP_JUMP = 2'd1,
        OP_EXIT = 2'd2,
        OP_RSVD = 2'd3
    } opcode_e;

    typedef enum logic [1:0] {
        PICK,
        REQ,
        WAIT,
        EXEC
    } ctrl_state_e;

    typedef enum logic [1:0] {
        UPD_ADVANCE,
        UPD_JUMP,
        UPD_RETIRE
    } upd_kind_e;

    typedef struct packed {
        pc_t         pc;
        addr_t       dp_addr;
        tblock_idx_t tblock_idx;
        tgroup_id_t  tgroup_id;
    } alloc_t;

    typedef struct packed {
        logic      valid;
        warp_idx_t idx;
        upd_kind_e kind;
        pc_t       pc;
    } warp_upd_t;

    // Read address and read data channels only
    typedef struct packed {
        logic       ar_valid;
        warp_idx_t  ar_id;
        imem_addr_t ar_addr;
        logic       r_ready;
    } imem_req_t;

    typedef struct packed {
        logic      ar_ready;
        logic      r_valid;
        warp_idx_t r_id;
        inst_t     r_data;
    } imem_rsp_t;

endpackage : cc_pkg

//--- hdl/cluster_ctrl.sv
/*
 * Cluster controller
 * Fetches, decodes and executes one instruction of the picked warp at a time
 */
`timescale 1ns/1ps

module cluster_ctrl (
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  logic                pick_valid_i,
    input  cc_pkg::warp_idx_t   pick_idx_i,
    input  cc_pkg::pc_t         pick_pc_i,
    input  cc_pkg::tgroup_id_t  pick_tgroup_i,

    output cc_pkg::warp_upd_t   upd_o,

    output cc_pkg::imem_req_t   imem_req_o,
    input  cc_pkg::imem_rsp_t   imem_rsp_i,

    output logic                done_push_o,
    output cc_pkg::tgroup_id_t  done_id_o,
    input  logic                done_full_i
);

    cc_pkg::ctrl_state_e state_q, state_d;
    cc_pkg::warp_idx_t   cur_idx_q;
    cc_pkg::pc_t         cur_pc_q;
    cc_pkg::tgroup_id_t  cur_tgroup_q;
    cc_pkg::inst_t       inst_q;
    cc_pkg::opcode_e     opcode;
    cc_pkg::pc_t         jump_tgt;
    logic                ar_hs;
    logic                r_hs;

    assign imem_req_o.ar_valid = (state_q == cc_pkg::REQ);
    assign imem_req_o.ar_id    = cur_idx_q;
    // Byte address of a 32-bit instruction
    assign imem_req_o.ar_addr  = {cur_pc_q, 2'b00};
    assign imem_req_o.r_ready  = (state_q == cc_pkg::WAIT);

    assign ar_hs = imem_req_o.ar_valid && imem_rsp_i.ar_ready;
    assign r_hs  = imem_req_o.r_ready && imem_rsp_i.r_valid;

    assign opcode   = cc_pkg::opcode_e'(inst_q[31:30]);
    assign jump_tgt = cc_pkg::pc_t'(inst_q[15:0]);

    assign done_id_o = cur_tgroup_q;

    always_comb begin
        state_d     = state_q;
        upd_o.valid = 1'b0;
        upd_o.idx   = cur_idx_q;
        upd_o.kind  = cc_pkg::UPD_ADVANCE;
        upd_o.pc    = cur_pc_q + cc_pkg::pc_t'(1);
        done_push_o = 1'b0;

        unique case (state_q)
            cc_pkg::PICK: begin
                if (pick_valid_i) begin
                    state_d = cc_pkg::REQ;
                end
            end
            cc_pkg::REQ: begin
                if (ar_hs) begin
                    state_d = cc_pkg::WAIT;
                end
            end
            cc_pkg::WAIT: begin
                if (r_hs) begin
                    state_d = cc_pkg::EXEC;
                end
            end
            cc_pkg::EXEC: begin
                unique case (opcode)
                    cc_pkg::OP_JUMP: begin
                        upd_o.valid = 1'b1;
                        upd_o.kind  = cc_pkg::UPD_JUMP;
                        upd_o.pc    = jump_tgt;
                        state_d     = cc_pkg::PICK;
                    end
                    cc_pkg::OP_EXIT: begin
                        // Hold the warp until the completion queue has room
                        if (!done_full_i) begin
                            upd_o.valid = 1'b1;
                            upd_o.kind  = cc_pkg::UPD_RETIRE;
                            done_push_o = 1'b1;
                            state_d     = cc_pkg::PICK;
                        end
                    end
                    default: begin
                        // NOP and the reserved opcode just advance
                        upd_o.valid = 1'b1;
                        state_d     = cc_pkg::PICK;
                    end
                endcase
            end
            default: begin
                state_d = cc_pkg::PICK;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= cc_pkg::PICK;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == cc_pkg::PICK && pick_valid_i) begin
            cur_idx_q    <= pick_idx_i;
            cur_pc_q     <= pick_pc_i;
            cur_tgroup_q <= pick_tgroup_i;
        end
        if (r_hs) begin
            inst_q <= imem_rsp_i.r_data;
        end
    end

    // Request must not change or drop before the memory accepts it
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        imem_req_o.ar_valid && !imem_rsp_i.ar_ready |=>
            imem_req_o.ar_valid && $stable(imem_req_o.ar_id) && $stable(imem_req_o.ar_addr))
        else $error("cluster_ctrl: AR channel changed before ar_ready");

    // Only one fetch is in flight, so the response belongs to it
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        r_hs |-> imem_rsp_i.r_id == imem_req_o.ar_id)
        else $error("cluster_ctrl: response id does not match request id");

endmodule : cluster_ctrl

//--- hdl/compute_cluster.sv
/*
 * Compute cluster
 * Warp table, control FSM and completion queue around one instruction port
 */
`timescale 1ns/1ps

module compute_cluster #(
    parameter int unsigned NumWarps  = 8,
    parameter int unsigned DoneDepth = 4
) (
    input  logic               clk_i,
    input  logic               rst_n_i,

    // Block start from the scheduler
    output logic               warp_free_o,
    input  logic               allocate_warp_i,
    input  cc_pkg::alloc_t     alloc_i,

    // Block completion
    input  logic               tblock_done_ready_i,
    output logic               tblock_done_o,
    output cc_pkg::tgroup_id_t tblock_done_id_o,

    output cc_pkg::imem_req_t  imem_req_o,
    input  cc_pkg::imem_rsp_t  imem_rsp_i
);

    logic               pick_valid;
    cc_pkg::warp_idx_t  pick_idx;
    cc_pkg::pc_t        pick_pc;
    cc_pkg::tgroup_id_t pick_tgroup;
    cc_pkg::warp_upd_t  warp_upd;
    logic               done_push;
    cc_pkg::tgroup_id_t done_id;
    logic               done_full;

    warp_table #(
        .NumWarps( NumWarps )
    ) i_warp_table (
        .clk_i        ( clk_i           ),
        .rst_n_i      ( rst_n_i         ),
        .alloc_i      ( allocate_warp_i ),
        .alloc_data_i ( alloc_i         ),
        .warp_free_o  ( warp_free_o     ),
        .pick_valid_o ( pick_valid      ),
        .pick_idx_o   ( pick_idx        ),
        .pick_pc_o    ( pick_pc         ),
        .pick_tgroup_o( pick_tgroup     ),
        .upd_i        ( warp_upd        )
    );

    cluster_ctrl i_cluster_ctrl (
        .clk_i        ( clk_i       ),
        .rst_n_i      ( rst_n_i     ),
        .pick_valid_i ( pick_valid  ),
        .pick_idx_i   ( pick_idx    ),
        .pick_pc_i    ( pick_pc     ),
        .pick_tgroup_i( pick_tgroup ),
        .upd_o        ( warp_upd    ),
        .imem_req_o   ( imem_req_o  ),
        .imem_rsp_i   ( imem_rsp_i  ),
        .done_push_o  ( done_push   ),
        .done_id_o    ( done_id     ),
        .done_full_i  ( done_full   )
    );

    done_fifo #(
        .Depth( DoneDepth )
    ) i_done_fifo (
        .clk_i    ( clk_i               ),
        .rst_n_i  ( rst_n_i             ),
        .push_i   ( done_push           ),
        .push_id_i( done_id             ),
        .full_o   ( done_full           ),
        .valid_o  ( tblock_done_o       ),
        .id_o     ( tblock_done_id_o    ),
        .ready_i  ( tblock_done_ready_i )
    );

endmodule : compute_cluster

//--- hdl/compute_cluster_synth_wrapper.sv
/*
 * Compute cluster synthesis top
 * Flattens the allocate record and instruction-port structs into plain ports
 */
`timescale 1ns/1ps

module compute_cluster_synth_wrapper #(
    parameter int unsigned NumWarps  = 8,
    parameter int unsigned DoneDepth = 4
) (
    input  logic                clk_i,
    input  logic                rst_n_i,

    output logic                warp_free_o,
    input  logic                allocate_warp_i,
    input  cc_pkg::pc_t         allocate_pc_i,
    input  cc_pkg::addr_t       allocate_dp_addr_i,
    input  cc_pkg::tblock_idx_t allocate_tblock_idx_i,
    input  cc_pkg::tgroup_id_t  allocate_tgroup_id_i,

    input  logic                tblock_done_ready_i,
    output logic                tblock_done_o,
    output cc_pkg::tgroup_id_t  tblock_done_id_o,

    output logic                imem_ar_valid_o,
    output cc_pkg::warp_idx_t   imem_ar_id_o,
    output cc_pkg::imem_addr_t  imem_ar_addr_o,
    input  logic                imem_ar_ready_i,

    input  logic                imem_r_valid_i,
    input  cc_pkg::warp_idx_t   imem_r_id_i,
    input  cc_pkg::inst_t       imem_r_data_i,
    output logic                imem_r_ready_o
);

    cc_pkg::alloc_t    alloc;
    cc_pkg::imem_req_t imem_req;
    cc_pkg::imem_rsp_t imem_rsp;

    assign alloc.pc         = allocate_pc_i;
    assign alloc.dp_addr    = allocate_dp_addr_i;
    assign alloc.tblock_idx = allocate_tblock_idx_i;
    assign alloc.tgroup_id  = allocate_tgroup_id_i;

    assign imem_ar_valid_o = imem_req.ar_valid;
    assign imem_ar_id_o    = imem_req.ar_id;
    assign imem_ar_addr_o  = imem_req.ar_addr;
    assign imem_r_ready_o  = imem_req.r_ready;

    assign imem_rsp.ar_ready = imem_ar_ready_i;
    assign imem_rsp.r_valid  = imem_r_valid_i;
    assign imem_rsp.r_id     = imem_r_id_i;
    assign imem_rsp.r_data   = imem_r_data_i;

    compute_cluster #(
        .NumWarps ( NumWarps  ),
        .DoneDepth( DoneDepth )
    ) i_cc (
        .clk_i              ( clk_i               ),
        .rst_n_i            ( rst_n_i             ),
        .warp_free_o        ( warp_free_o         ),
        .allocate_warp_i    ( allocate_warp_i     ),
        .alloc_i            ( alloc               ),
        .tblock_done_ready_i( tblock_done_ready_i ),
        .tblock_done_o      ( tblock_done_o       ),
        .tblock_done_id_o   ( tblock_done_id_o    ),
        .imem_req_o         ( imem_req            ),
        .imem_rsp_i         ( imem_rsp            )
    );

endmodule : compute_cluster_synth_wrapper

//--- hdl/done_fifo.sv
/*
 * Completion queue
 * Buffers retired thread-group ids behind a valid/ready output
 */
`timescale 1ns/1ps

module done_fifo #(
    parameter int unsigned Depth = 4
) (
    input  logic               clk_i,
    input  logic               rst_n_i,

    input  logic               push_i,
    input  cc_pkg::tgroup_id_t push_id_i,
    output logic               full_o,

    output logic               valid_o,
    output cc_pkg::tgroup_id_t id_o,
    input  logic               ready_i
);

    localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntWidth = $clog2(Depth + 1);

    cc_pkg::tgroup_id_t  mem_q [Depth];
    logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
    logic [CntWidth-1:0] count_q;
    logic                pop;

    assign full_o  = (count_q == CntWidth'(Depth));
    assign valid_o = (count_q != '0);
    assign id_o    = mem_q[rd_ptr_q];
    assign pop     = valid_o && ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Push and pop together leave the count unchanged
            if (push_i && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_id_i;
        end
    end

    // The controller stalls EXIT while the queue is full
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> !full_o)
        else $error("done_fifo: push into a full queue");

endmodule : done_fifo

//--- hdl/warp_table.sv
/*
 * Warp table
 * Per-warp slot records, lowest-free allocation and round-robin pick
 */
`timescale 1ns/1ps

module warp_table #(
    parameter int unsigned NumWarps = 8
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    input  logic                   alloc_i,
    input  cc_pkg::alloc_t         alloc_data_i,
    output logic                   warp_free_o,

    output logic                   pick_valid_o,
    output cc_pkg::warp_idx_t      pick_idx_o,
    output cc_pkg::pc_t            pick_pc_o,
    output cc_pkg::tgroup_id_t     pick_tgroup_o,

    input  cc_pkg::warp_upd_t      upd_i
);

    logic [NumWarps-1:0] valid_q;
    cc_pkg::alloc_t      rec_q [NumWarps];
    cc_pkg::warp_idx_t   rr_q;
    cc_pkg::warp_idx_t   free_idx;
    logic                alloc_en;

    // Lowest empty slot
    always_comb begin
        free_idx = '0;
        for (int i = NumWarps - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = cc_pkg::warp_idx_t'(i);
            end
        end
    end

    assign warp_free_o = ~&valid_q;
    assign alloc_en    = alloc_i && warp_free_o;

    // Search starts one past the last served warp and wraps around
    always_comb begin
        int unsigned cand;
        pick_valid_o = 1'b0;
        pick_idx_o   = '0;
        for (int unsigned i = 1; i <= NumWarps; i++) begin
            cand = (32'(rr_q) + i) % NumWarps;
            if (!pick_valid_o && valid_q[cand]) begin
                pick_valid_o = 1'b1;
                pick_idx_o   = cc_pkg::warp_idx_t'(cand);
            end
        end
    end

    assign pick_pc_o     = rec_q[pick_idx_o].pc;
    assign pick_tgroup_o = rec_q[pick_idx_o].tgroup_id;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else begin
            if (alloc_en) begin
                valid_q[free_idx] <= 1'b1;
            end
            if (upd_i.valid) begin
                rr_q <= upd_i.idx;
                if (upd_i.kind == cc_pkg::UPD_RETIRE) begin
                    valid_q[upd_i.idx] <= 1'b0;
                end
            end
        end
    end

    // Record payload, the valid bit qualifies it
    always_ff @(posedge clk_i) begin
        if (alloc_en) begin
            rec_q[free_idx] <= alloc_data_i;
        end
        if (upd_i.valid && upd_i.kind != cc_pkg::UPD_RETIRE) begin
            rec_q[upd_i.idx].pc <= upd_i.pc;
        end
    end

    // Scheduler must only start a block while a slot is free
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        alloc_i |-> warp_free_o)
        else $error("warp_table: allocate without a free slot");

endmodule : warp_table
